// File: list.f
source/obj_scan_pkg.sv
source/obj_table_ram.sv
source/obj_scan_ctrl.sv
source/obj_entry_fetch.sv
source/obj_tile_match.sv
source/obj_draw_issue.sv
source/obj_scan_top.sv
tb/tb_clock.sv
tb/tb_obj_scan.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_obj_scan -o sim_obj_scan
./obj_dir/sim_obj_scan | tee sim.log
if grep -q "All checks passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: source/obj_draw_issue.sv
// ========================================
// horizontal expansion, one command per tile
// dr_start is accepted only with dr_idle high and
// is followed by at least two quiet cycles
// tiles with bit 9 of x set are skipped
// ========================================
module obj_draw_issue (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            inzone,
    input  logic [3:0]                      vsub,
    input  logic [obj_scan_pkg::WORD_W-1:0] code_mn,
    input  logic [9:0]                      ent_x,
    input  logic [obj_scan_pkg::WORD_W-1:0] ent_attr,
    input  logic [2:0]                      ent_prio,
    input  logic [1:0]                      ent_bank,
    input  logic                            dr_idle,
    output logic                            busy,
    output logic                            dr_start,
    output logic [obj_scan_pkg::WORD_W-1:0] dr_code,
    output logic [obj_scan_pkg::WORD_W-1:0] dr_attr,
    output logic [8:0]                      dr_hpos,
    output logic [2:0]                      dr_prio,
    output logic [1:0]                      dr_bank
);
    import obj_scan_pkg::*;

    logic [9:0]        obj_x;     // aligned with the match outputs
    logic [WORD_W-1:0] obj_attr;
    logic [2:0]        obj_prio;
    logic [1:0]        obj_bank;
    logic [3:0]        n;
    logic [3:0]        tile_n;
    logic [3:0]        subn;
    logic [9:0]        eff_x;
    logic              start_d;
    logic              can_issue;
    logic              issue;
    logic              handled;
    logic              last_tile;

    assign tile_n    = obj_attr[ATTR_TN_HI:ATTR_TN_LO];
    assign subn      = obj_attr[ATTR_HFLIP] ? tile_n - n : n;
    assign eff_x     = obj_x + 10'(subn) * 10'(TILE_W);
    assign can_issue = dr_idle && !dr_start && !start_d;
    assign issue     = inzone && !eff_x[9] && can_issue;
    assign handled   = inzone && (eff_x[9] || can_issue);   // drawn or skipped
    assign last_tile = n == tile_n;
    assign busy      = inzone && !(handled && last_tile);

    always_ff @(posedge clk) begin
        if (!busy) begin
            obj_x    <= ent_x;
            obj_attr <= ent_attr;
            obj_prio <= ent_prio;
            obj_bank <= ent_bank;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            n        <= '0;
            start_d  <= 1'b0;
            dr_start <= 1'b0;
            dr_code  <= '0;
            dr_attr  <= '0;
            dr_hpos  <= '0;
            dr_prio  <= '0;
            dr_bank  <= '0;
        end else begin
            start_d  <= dr_start;
            dr_start <= issue;
            if (handled) begin
                n <= last_tile ? '0 : n + 1'b1;
            end
            if (issue) begin
                dr_code <= code_mn + WORD_W'(n);   // code follows n, not subn
                dr_attr <= {4'd0, vsub, obj_attr[7:0]};
                dr_hpos <= eff_x[8:0] - 9'd1;
                dr_prio <= obj_prio;
                dr_bank <= obj_bank;
            end
        end
    end

    // renderer must still be idle when the pulse arrives
    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        dr_start |-> dr_idle);

endmodule

// File: source/obj_entry_fetch.sv
// ========================================
// entry stage, end test plus scroll and bias
// list_end is a single-cycle pulse
// fields hold while stall is high
// ========================================
module obj_entry_fetch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          scanning,
    input  logic [9:0]                    off_x,
    input  logic [9:0]                    off_y,
    input  logic [obj_scan_pkg::WORD_W-1:0] table_x,
    input  logic [obj_scan_pkg::WORD_W-1:0] table_y,
    input  logic [obj_scan_pkg::WORD_W-1:0] table_code,
    input  logic [obj_scan_pkg::WORD_W-1:0] table_attr,
    output logic                          list_end,
    output logic                          ent_valid,
    output logic [9:0]                    ent_x,
    output logic [9:0]                    ent_y,
    output logic [obj_scan_pkg::WORD_W-1:0] ent_code,
    output logic [obj_scan_pkg::WORD_W-1:0] ent_attr,
    output logic [2:0]                    ent_prio,
    output logic [1:0]                    ent_bank
);
    import obj_scan_pkg::*;

    logic       end_cond;
    logic       noscroll;
    logic [9:0] sx;
    logic [9:0] sy;

    assign end_cond = table_y[Y_END] ||
                      table_attr[ATTR_TM_HI:ATTR_TN_LO] == ATTR_END_CODE;
    assign noscroll = table_attr[ATTR_NOSCROLL];
    assign sx       = noscroll ? '0 : off_x;
    assign sy       = noscroll ? '0 : off_y;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            list_end  <= 1'b0;
            ent_valid <= 1'b0;
        end else begin
            list_end <= scanning && !stall && end_cond;
            if (!stall) begin
                ent_valid <= scanning && !end_cond;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scanning && !stall && !end_cond) begin
            ent_x    <= table_x[9:0] + X_BIAS - sx;   // wraps at 10 bits
            ent_y    <= table_y[9:0] + Y_BIAS - sy;
            ent_code <= table_code;
            ent_attr <= table_attr;
            ent_prio <= table_x[X_PRIO_HI:X_PRIO_LO];
            ent_bank <= table_y[Y_BANK_HI:Y_BANK_LO];
        end
    end

endmodule

// File: source/obj_scan_ctrl.sv
// ========================================
// scan control, one pass over the table per line
// table_addr is combinational: it repeats the last read
// address during a stall so the registered RAM output holds
// the entry at the last index is never drawn, it ends the list
// ========================================
module obj_scan_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              flip,
    input  logic [8:0]                        vrender1,  // two lines ahead of display
    input  logic [8:0]                        hdump,
    input  logic                              list_end,
    input  logic                              busy,
    output logic                              line,
    output logic                              done,
    output logic [obj_scan_pkg::TABLE_AW-1:0] table_addr,
    output logic [8:0]                        vrenderf,
    output logic                              stall,
    output logic                              scanning
);
    import obj_scan_pkg::*;

    logic                last_start;
    logic                start_pulse;
    logic                scan_q;
    logic                last_addr;
    logic [TABLE_AW-1:0] rd_addr;   // address whose data sits on the RAM output

    assign start_pulse = (hdump == LINE_START_H) && !last_start;
    assign stall       = busy;      // draw stage holds the whole pipe
    assign last_addr   = &rd_addr;

    // RAM data is a live entry only in these cycles
    assign scanning = scan_q && !start_pulse && !list_end && !last_addr;

    always_comb begin
        if (start_pulse) begin
            table_addr = '0;
        end else if (scan_q && !stall) begin
            table_addr = rd_addr + 1'b1;
        end else begin
            table_addr = rd_addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_start <= 1'b0;
            line       <= 1'b0;
            done       <= 1'b1;
            scan_q     <= 1'b0;
            rd_addr    <= '0;
            vrenderf   <= '0;
        end else begin
            last_start <= hdump == LINE_START_H;
            rd_addr    <= table_addr;
            if (start_pulse) begin
                // also aborts a scan still in progress
                line     <= ~line;
                done     <= 1'b0;
                scan_q   <= 1'b1;
                vrenderf <= vrender1 ^ {1'b0, {8{flip}}};
            end else begin
                if (scan_q && (list_end || (last_addr && !stall))) begin
                    scan_q  <= 1'b0;
                    rd_addr <= '0;
                end
                if (!scan_q && !done && !busy) begin
                    done <= 1'b1;   // pipe drained
                end
            end
        end
    end

    // the scan must return the address to the table start
    done_addr_zero: assert property (@(posedge clk) disable iff (rst)
        done |-> table_addr == '0);

endmodule

// File: source/obj_scan_pkg.sv
// ========================================
// shared constants of the sprite line scanner
// table entries are four 16-bit words: x, y, code, attr
// 1024 entries, the last index always ends the list
// ========================================
package obj_scan_pkg;

    localparam int TABLE_AW = 10;
    localparam int WORD_W   = 16;

    // word select inside one entry
    localparam logic [1:0] WSEL_X    = 2'd0;
    localparam logic [1:0] WSEL_Y    = 2'd1;
    localparam logic [1:0] WSEL_CODE = 2'd2;
    localparam logic [1:0] WSEL_ATTR = 2'd3;

    localparam logic [8:0] LINE_START_H  = 9'h1d0;
    localparam logic [9:0] X_BIAS        = 10'h40;
    localparam logic [9:0] Y_BIAS        = 10'h10;
    localparam int         TILE_W        = 16;     // pixels per tile side
    localparam logic [7:0] ATTR_END_CODE = 8'hff;

    // attribute word
    localparam int ATTR_TM_HI    = 15;
    localparam int ATTR_TM_LO    = 12;
    localparam int ATTR_TN_HI    = 11;
    localparam int ATTR_TN_LO    = 8;
    localparam int ATTR_NOSCROLL = 7;
    localparam int ATTR_VFLIP    = 6;
    localparam int ATTR_HFLIP    = 5;

    // y and x words
    localparam int Y_END     = 15;
    localparam int Y_BANK_HI = 14;
    localparam int Y_BANK_LO = 13;
    localparam int X_PRIO_HI = 15;
    localparam int X_PRIO_LO = 13;

endpackage

// File: source/obj_scan_top.sv
// ========================================
// sprite line scanner top level
// renderer, timing and line buffers are external
// table is loaded through the tbl_* word port
// ========================================
module obj_scan_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              flip,
    input  logic [8:0]                        vrender1,
    input  logic [8:0]                        hdump,
    input  logic [9:0]                        off_x,
    input  logic [9:0]                        off_y,
    input  logic                              tbl_we,
    input  logic [obj_scan_pkg::TABLE_AW+1:0] tbl_waddr,
    input  logic [obj_scan_pkg::WORD_W-1:0]   tbl_wdata,
    output logic                              dr_start,
    input  logic                              dr_idle,
    output logic [obj_scan_pkg::WORD_W-1:0]   dr_code,
    output logic [obj_scan_pkg::WORD_W-1:0]   dr_attr,
    output logic [8:0]                        dr_hpos,
    output logic [2:0]                        dr_prio,
    output logic [1:0]                        dr_bank,
    output logic                              line,
    output logic                              done
);
    import obj_scan_pkg::*;

    logic [TABLE_AW-1:0] table_addr;
    logic [WORD_W-1:0]   table_x;
    logic [WORD_W-1:0]   table_y;
    logic [WORD_W-1:0]   table_code;
    logic [WORD_W-1:0]   table_attr;
    logic [8:0]          vrenderf;
    logic                list_end;
    logic                busy;
    logic                stall;
    logic                scanning;
    logic                ent_valid;
    logic [9:0]          ent_x;
    logic [9:0]          ent_y;
    logic [WORD_W-1:0]   ent_code;
    logic [WORD_W-1:0]   ent_attr;
    logic [2:0]          ent_prio;
    logic [1:0]          ent_bank;
    logic                inzone;
    logic [3:0]          vsub;
    logic [WORD_W-1:0]   code_mn;

    // port names match the wires above
    obj_table_ram   ram0   (.*);
    obj_scan_ctrl   ctrl0  (.*);
    obj_entry_fetch fetch0 (.*);
    obj_tile_match  match0 (.*);
    obj_draw_issue  issue0 (.*);

endmodule

// File: source/obj_table_ram.sv
// ========================================
// frame table, one array per entry word
// write port addresses single words: {entry, word select}
// read is registered, a whole entry per cycle
// no reset on contents
// ========================================
module obj_table_ram (
    input  logic                                clk,
    input  logic                                tbl_we,
    input  logic [obj_scan_pkg::TABLE_AW+1:0]   tbl_waddr,
    input  logic [obj_scan_pkg::WORD_W-1:0]     tbl_wdata,
    input  logic [obj_scan_pkg::TABLE_AW-1:0]   table_addr,
    output logic [obj_scan_pkg::WORD_W-1:0]     table_x,
    output logic [obj_scan_pkg::WORD_W-1:0]     table_y,
    output logic [obj_scan_pkg::WORD_W-1:0]     table_code,
    output logic [obj_scan_pkg::WORD_W-1:0]     table_attr
);
    import obj_scan_pkg::*;

    logic [WORD_W-1:0]   mem_x    [2**TABLE_AW];
    logic [WORD_W-1:0]   mem_y    [2**TABLE_AW];
    logic [WORD_W-1:0]   mem_code [2**TABLE_AW];
    logic [WORD_W-1:0]   mem_attr [2**TABLE_AW];
    logic [TABLE_AW-1:0] wentry;
    logic [1:0]          wsel;

    assign wentry = tbl_waddr[TABLE_AW+1:2];
    assign wsel   = tbl_waddr[1:0];

    always_ff @(posedge clk) begin
        if (tbl_we) begin
            case (wsel)
                WSEL_X:    mem_x[wentry]    <= tbl_wdata;
                WSEL_Y:    mem_y[wentry]    <= tbl_wdata;
                WSEL_CODE: mem_code[wentry] <= tbl_wdata;
                WSEL_ATTR: mem_attr[wentry] <= tbl_wdata;
            endcase
        end
        table_x    <= mem_x[table_addr];
        table_y    <= mem_y[table_addr];
        table_code <= mem_code[table_addr];
        table_attr <= mem_attr[table_addr];
    end

endmodule

// File: source/obj_tile_match.sv
// ========================================
// vertical match against the latched line
// row arithmetic is modulo 1024
// outputs hold while stall is high
// ========================================
module obj_tile_match (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            stall,
    input  logic                            ent_valid,
    input  logic [9:0]                      ent_y,
    input  logic [obj_scan_pkg::WORD_W-1:0] ent_code,
    input  logic [obj_scan_pkg::WORD_W-1:0] ent_attr,
    input  logic [8:0]                      vrenderf,
    output logic                            inzone,
    output logic [3:0]                      vsub,
    output logic [obj_scan_pkg::WORD_W-1:0] code_mn
);
    import obj_scan_pkg::*;

    logic [9:0]  row;
    logic [3:0]  tile_m;
    logic [3:0]  trow;
    logic [10:0] span;
    logic        vflip;

    assign row    = {1'b0, vrenderf} - ent_y;
    assign tile_m = ent_attr[ATTR_TM_HI:ATTR_TM_LO];
    assign vflip  = ent_attr[ATTR_VFLIP];
    assign span   = (11'(tile_m) + 11'd1) * 11'(TILE_W);   // sprite height in lines
    assign trow   = vflip ? tile_m - row[7:4] : row[7:4];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inzone <= 1'b0;
        end else if (!stall) begin
            inzone <= ent_valid && ({1'b0, row} < span);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            vsub    <= row[3:0] ^ {4{vflip}};
            code_mn <= ent_code + WORD_W'(trow) * WORD_W'(TILE_W);  // one code row per tile row
        end
    end

endmodule

// File: tb/tb_clock.sv
// ========================================
// testbench clock and reset
// period 8, rst high for the first 10 rising edges
// ========================================
module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;   // released off the edge like the other inputs
    end

endmodule

// File: tb/tb_obj_scan.sv
// ========================================
// testbench for the sprite line scanner
// plays the renderer and the video timing
// the table is rewritten only between scans, while done is high
// every table must hold an end marker before index 1023
// ========================================
module tb_obj_scan;

    localparam int         NUM_LINES  = 21;      // lines run by all tests together
    localparam logic [8:0] LINE_START = 9'h1d0;

    logic        clk, rst, flip, tbl_we, dr_start, line, done;
    logic        dr_idle = 1'b1;
    logic [8:0]  vrender1, dr_hpos;
    logic [8:0]  hdump = '0;
    logic [9:0]  off_x, off_y;
    logic [11:0] tbl_waddr;
    logic [15:0] tbl_wdata, dr_code, dr_attr;
    logic [2:0]  dr_prio;
    logic [1:0]  dr_bank;

    logic [15:0] sh_x [1024];       // copy of the table contents
    logic [15:0] sh_y [1024];
    logic [15:0] sh_code [1024];
    logic [15:0] sh_attr [1024];
    logic [45:0] exp_q [$];         // {code, attr, hpos, prio, bank}
    logic [45:0] exp_cmd;
    logic [15:0] lfsr = 16'd49453;
    logic [2:0]  idle_wait = '0;
    logic        start_seen = 1'b0;  // dr_start as the renderer registers it
    int          errors = 0;
    int          checked = 0;
    string       test_name = "reset";

    tb_clock     clk_gen0 (.clk(clk), .rst(rst));
    obj_scan_top dut0 (.*);

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // expected commands of one line, in issue order
    function automatic void expect_line(input logic [8:0] vr);
        logic [8:0]  vline;
        logic [9:0]  ex, ey, row, effx;
        logic [3:0]  tm, tn, trow, subn, vsub;
        logic [15:0] a, cmn;
        vline = flip ? {vr[8], ~vr[7:0]} : vr;
        for (int i = 0; i < 1023; i++) begin
            a = sh_attr[i];
            if (sh_y[i][15] || a[15:8] == 8'hff) break;
            ex  = sh_x[i][9:0] + 10'h40 - (a[7] ? 10'd0 : off_x);
            ey  = sh_y[i][9:0] + 10'h10 - (a[7] ? 10'd0 : off_y);
            row = {1'b0, vline} - ey;
            tm  = a[15:12];
            tn  = a[11:8];
            if (int'(row) >= 16 * (int'(tm) + 1)) continue;   // outside the span
            trow = a[6] ? tm - row[7:4] : row[7:4];
            vsub = a[6] ? ~row[3:0] : row[3:0];
            cmn  = sh_code[i] + {8'd0, trow, 4'd0};
            for (int n = 0; n <= int'(tn); n++) begin
                subn = a[5] ? tn - 4'(n) : 4'(n);
                effx = ex + {2'd0, subn, 4'd0};
                if (!effx[9]) begin
                    exp_q.push_back({cmn + 16'(n), 4'd0, vsub, a[7:0], effx[8:0] - 9'd1,
                                     sh_x[i][15:13], sh_y[i][14:13]});
                end
            end
        end
    endfunction

    task automatic check_field(input string fld, input logic [15:0] expv,
                               input logic [15:0] act);
        if (act !== expv) begin
            errors++;
            $display("ERROR %s %s: expected %h, got %h", test_name, fld, expv, act);
        end
    endtask

    // entry packed as {x, y, code, attr}
    task automatic write_entry(input logic [9:0] idx, input logic [63:0] ent);
        {sh_x[idx], sh_y[idx], sh_code[idx], sh_attr[idx]} = ent;
        for (int w = 0; w < 4; w++) begin
            tbl_we    = 1'b1;
            tbl_waddr = {idx, 2'(w)};
            tbl_wdata = ent[63 - 16 * w -: 16];
            @(posedge clk);
            #1;
        end
        tbl_we = 1'b0;
    endtask

    task automatic run_lines(input logic [8:0] first, input int count, input int step);
        logic prev_line;
        for (int k = 0; k < count; k++) begin
            vrender1  = first + 9'(k * step);
            prev_line = line;
            do begin
                @(posedge clk);
            end while (hdump != LINE_START);
            #1;
            if (done !== 1'b0) begin
                errors++;
                $display("ERROR %s done: expected 0, got %b", test_name, done);
            end
            while (done !== 1'b1) begin
                @(posedge clk);
                #1;
            end
            if (line !== ~prev_line) begin
                errors++;
                $display("ERROR %s line: expected %b, got %b", test_name, ~prev_line, line);
            end
            repeat (2) @(posedge clk);   // last command reaches the compare
            #1;
        end
    endtask

    always @(posedge clk) begin
        #1;
        hdump = hdump + 9'd1;   // 512 dots per line
    end

    // renderer busy for 0 to 7 cycles after each start it registers
    always @(posedge clk) begin
        #1;
        if (start_seen) begin
            repeat (3) begin
                lfsr      = lfsr_step(lfsr);
                idle_wait = {idle_wait[1:0], lfsr[0]};
            end
        end else if (idle_wait != 0) begin
            idle_wait = idle_wait - 3'd1;
        end
        dr_idle    = idle_wait == 0;
        start_seen = dr_start;
    end

    always @(negedge clk) begin
        if (!rst && hdump == LINE_START) begin
            if (exp_q.size() != 0) begin
                errors += exp_q.size();
                $display("%s: %0d expected commands never arrived", test_name, exp_q.size());
                exp_q.delete();
            end
            expect_line(vrender1);
        end
        if (!rst && dr_start) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: draw command with no expected command left", test_name);
            end else begin
                exp_cmd = exp_q.pop_front();
                checked++;
                check_field("code", exp_cmd[45:30], dr_code);
                check_field("attr", exp_cmd[29:14], dr_attr);
                check_field("hpos", 16'(exp_cmd[13:5]), 16'(dr_hpos));
                check_field("prio", 16'(exp_cmd[4:2]), 16'(dr_prio));
                check_field("bank", 16'(exp_cmd[1:0]), 16'(dr_bank));
            end
        end
    end

    initial begin
        #((NUM_LINES + 2) * 512 * 8);
        $display("timeout: scans did not finish within %0d lines", NUM_LINES + 2);
        $display("Checks failed");
        $finish;
    end

    initial begin
        flip      = 1'b0;
        vrender1  = '0;
        off_x     = 10'h020;
        off_y     = 10'h008;
        tbl_we    = 1'b0;
        tbl_waddr = '0;
        tbl_wdata = '0;
        @(negedge rst);
        @(posedge clk);
        #1;
        if (dr_start !== 1'b0 || done !== 1'b1 || line !== 1'b0) begin
            errors++;
            $display("ERROR %s: expected start 0 done 1 line 0, got %b %b %b",
                     test_name, dr_start, done, line);
        end

        test_name = "single_tile";
        write_entry(10'd0, 64'ha050_4060_1230_0012);   // prio 5, bank 2
        write_entry(10'd1, 64'h2100_2058_0400_0083);   // no-scroll
        write_entry(10'd2, 64'h0030_0100_0077_0001);   // never in span here
        write_entry(10'd3, 64'h0000_8000_0000_0000);
        run_lines(9'h066, 6, 4);

        test_name = "multi_tile";
        write_entry(10'd0, 64'h0080_0100_0500_1265);   // 3x2 tiles, hflip and vflip
        write_entry(10'd1, 64'h01b0_0108_0600_0309);   // last tile at x 0x200
        write_entry(10'd2, 64'h03b8_0100_0700_01a0);   // no-scroll, hflip, x wraps
        run_lines(9'h106, 9, 4);

        test_name = "end_code";
        write_entry(10'd0, 64'h0060_0040_0800_0004);
        write_entry(10'd1, 64'h0070_0040_0880_ff00);
        write_entry(10'd2, 64'h0090_0040_0900_0005);   // after the end, in span
        run_lines(9'h04a, 1, 1);
        test_name = "end_flag";
        write_entry(10'd1, 64'h0070_8040_0880_0001);
        run_lines(9'h04a, 1, 1);

        test_name = "flip";
        flip = 1'b1;
        write_entry(10'd0, 64'h0060_0000_0a00_0002);
        write_entry(10'd1, 64'h0080_00ea_0b00_0003);   // would hit only without flip
        write_entry(10'd2, 64'h0000_8000_0000_0000);
        run_lines(9'h0f2, 4, 3);

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            errors += exp_q.size();
            $display("%0d expected commands never arrived", exp_q.size());
        end
        $display("%0d commands checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
